// File: design/apbRequester.sv
`timescale 1ns/10ps

module apbRequester #(
    parameter int AddrWidth = 12
) (
    input  logic iClk,
    input  logic nRst,
    memIf.bus mem,
    output logic pSel,
    output logic pEnable,
    output logic pWrite,
    output logic [AddrWidth-1:0] pAddr,
    output cpuPkg::wordT pWdata,
    input  cpuPkg::wordT pRdata,
    input  logic pReady
);

    typedef enum logic [1:0] {Idle, Setup, Access} apbStateT;

    apbStateT state;
    logic launch;
    logic complete;

    // New request, but not the one just finished in the done cycle
    assign launch = (state == Idle) && mem.req && !mem.done;
    // Access phase ends when the slave is ready
    assign complete = (state == Access) && pReady;

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            state <= Idle;
            mem.done <= 1'b0;
            pWrite <= 1'b0;
        end else begin
            mem.done <= complete;
            case (state)
                Idle: begin
                    if (launch) begin
                        state <= Setup;
                        pWrite <= mem.write;
                    end
                end
                Setup: state <= Access;
                Access: begin
                    if (complete) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Transfer payload
    always_ff @(posedge iClk) begin
        if (launch) begin
            pAddr <= mem.addr;
            pWdata <= mem.wdata;
        end
        // Read data held until the next transfer completes
        if (complete) begin
            mem.rdata <= pRdata;
        end
    end

    assign pSel = (state != Idle);
    assign pEnable = (state == Access);

    // Every access phase is entered from a setup phase
    accessAfterSetup: assert property (@(posedge iClk) disable iff (!nRst)
        pEnable |-> pSel && $past(pSel));

    // Address and direction frozen for the whole transfer
    xferStable: assert property (@(posedge iClk) disable iff (!nRst)
        pSel && !complete |=> $stable(pAddr) && $stable(pWrite));

endmodule

// File: design/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic iClk,
    input  logic nRst,
    memIf.core mem,
    ctrlIf.ctrl ctl,
    output logic halted
);

    cpuPkg::stepT step;
    cpuPkg::wordT ir;
    cpuPkg::opcodeT opcode;
    cpuPkg::brCondT brCond;
    cpuPkg::regAddrT ra;
    cpuPkg::regAddrT rb;
    cpuPkg::regAddrT rc;
    cpuPkg::aluOpT aluOp;
    logic isLd;
    logic isLi;
    logic isSt;
    logic isAddi;
    logic isBr;
    logic isOut;
    logic isHlt;
    logic fmtR;
    logic fmtI;
    logic isMemOp;
    logic stepReady;
    logic freeze;
    logic brTaken;

    // Fields
    assign opcode = cpuPkg::opcodeT'(ir[31:27]);
    assign ra = ir[26:23];
    assign rb = ir[22:19];
    assign rc = ir[18:15];
    // Condition overlaps the rb field
    assign brCond = cpuPkg::brCondT'(ir[20:19]);

    // Memory phases wait on the requester, all others take one cycle
    assign stepReady = (step == cpuPkg::StepFetch || (step == cpuPkg::StepMem && isMemOp))
                       ? mem.done : 1'b1;
    // HLT parks the counter in DECODE
    assign freeze = (step == cpuPkg::StepDecode) && isHlt;

    // Step counter, rotates one-hot
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            step <= cpuPkg::StepFetch;
        end else if (stepReady && !freeze) begin
            step <= cpuPkg::stepT'({step[3:0], step[4]});
        end
    end

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            halted <= 1'b0;
        end else if (freeze) begin
            halted <= 1'b1;
        end
    end

    // Instruction register, loaded when the fetch read returns
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            ir <= {cpuPkg::OpNop, 27'd0};
        end else if (step == cpuPkg::StepFetch && mem.done) begin
            ir <= mem.rdata;
        end
    end

    // Register format ops and their ALU function
    // Unknown opcodes fall out of every class and act as NOP
    always_comb begin
        aluOp = cpuPkg::AluAdd;
        fmtR = 1'b1;
        case (opcode)
            cpuPkg::OpAdd: aluOp = cpuPkg::AluAdd;
            cpuPkg::OpSub: aluOp = cpuPkg::AluSub;
            cpuPkg::OpAnd: aluOp = cpuPkg::AluAnd;
            cpuPkg::OpOr:  aluOp = cpuPkg::AluOr;
            cpuPkg::OpSll: aluOp = cpuPkg::AluSll;
            cpuPkg::OpSrl: aluOp = cpuPkg::AluSrl;
            default: fmtR = 1'b0;
        endcase
    end

    // Immediate format, address or sum through the adder
    assign isLd = (opcode == cpuPkg::OpLd);
    assign isLi = (opcode == cpuPkg::OpLi);
    assign isSt = (opcode == cpuPkg::OpSt);
    assign isAddi = (opcode == cpuPkg::OpAddi);
    assign fmtI = isLd || isLi || isSt || isAddi;
    assign isMemOp = isLd || isSt;
    // Branch, port and machine formats
    assign isBr = (opcode == cpuPkg::OpBr);
    assign isOut = (opcode == cpuPkg::OpOut);
    assign isHlt = (opcode == cpuPkg::OpHlt);

    // Condition against flags of ra on port B
    always_comb begin
        case (brCond)
            cpuPkg::BrZero: brTaken = ctl.regZero;
            cpuPkg::BrNzro: brTaken = !ctl.regZero;
            cpuPkg::BrPos:  brTaken = !ctl.regZero && !ctl.regNeg;
            default:        brTaken = ctl.regNeg;
        endcase
    end

    // Port A is rb, forced to r0 for LI
    assign ctl.addrA = isLi ? '0 : rb;
    // Port B is rc for register ops, else ra (store data, branch test, OUT)
    assign ctl.addrB = fmtR ? rc : ra;
    // Write target is always ra
    assign ctl.addrC = ra;

    assign ctl.aluOp = aluOp;
    assign ctl.useImm = fmtI;
    // Sign-extended immediate, the branch offset uses the same field
    assign ctl.imm = {{(32 - cpuPkg::ImmWidth){ir[cpuPkg::ImmWidth-1]}},
                      ir[cpuPkg::ImmWidth-1:0]};

    // Per-step strobes
    assign ctl.rfWrite = (step == cpuPkg::StepWrite) && (fmtR || isLd || isLi || isAddi);
    assign ctl.wbFromMem = isLd;
    assign ctl.pcIncr = (step == cpuPkg::StepFetch) && mem.done;
    assign ctl.pcBranch = (step == cpuPkg::StepExec) && isBr && brTaken;
    assign ctl.memAddrFromAlu = (step == cpuPkg::StepMem);
    assign ctl.outLoad = (step == cpuPkg::StepWrite) && isOut;

    // Requests held for the whole phase
    assign mem.req = (step == cpuPkg::StepFetch) || ((step == cpuPkg::StepMem) && isMemOp);
    assign mem.write = (step == cpuPkg::StepMem) && isSt;

    stepOneHot: assert property (@(posedge iClk) disable iff (!nRst)
        $onehot(step));

    // Write-back only in WRITE, reached straight from MEM
    rfWriteInWrite: assert property (@(posedge iClk) disable iff (!nRst)
        ctl.rfWrite |-> (step == cpuPkg::StepWrite) && $past(step == cpuPkg::StepMem));

endmodule

// File: design/coreIfs.sv
`timescale 1ns/10ps

// Control unit to datapath
interface ctrlIf;
    cpuPkg::aluOpT aluOp;
    logic rfWrite;
    cpuPkg::regAddrT addrA;
    cpuPkg::regAddrT addrB;
    cpuPkg::regAddrT addrC;
    logic useImm;
    cpuPkg::wordT imm;
    logic wbFromMem;
    logic pcIncr;
    logic pcBranch;
    logic memAddrFromAlu;
    logic outLoad;
    // Flags of register port B, the branch-tested register
    logic regZero;
    logic regNeg;

    modport ctrl (
        output aluOp, rfWrite, addrA, addrB, addrC, useImm, imm,
        output wbFromMem, pcIncr, pcBranch, memAddrFromAlu, outLoad,
        input regZero, regNeg
    );
    modport dp (
        input aluOp, rfWrite, addrA, addrB, addrC, useImm, imm,
        input wbFromMem, pcIncr, pcBranch, memAddrFromAlu, outLoad,
        output regZero, regNeg
    );
endinterface

// Core to bus requester, req held until done
interface memIf #(parameter int AddrWidth = 12);
    logic req;
    logic write;
    logic [AddrWidth-1:0] addr;
    cpuPkg::wordT wdata;
    cpuPkg::wordT rdata;
    logic done;

    modport core (output req, write, addr, wdata, input rdata, done);
    modport bus (input req, write, addr, wdata, output rdata, done);
endinterface

// File: design/cpuPkg.sv
package cpuPkg;

    // Instruction field widths
    localparam int OpcodeWidth = 5;
    localparam int RegAddrWidth = 4;
    // Signed immediate and branch offset live in bits 18:0
    localparam int ImmWidth = 19;
    localparam int WordWidth = 32;

    typedef logic [WordWidth-1:0] wordT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    // Opcode in bits 31:27, encodings kept from the full ISA
    typedef enum logic [OpcodeWidth-1:0] {
        OpLd   = 5'd0,
        OpLi   = 5'd1,
        OpSt   = 5'd2,
        OpAdd  = 5'd3,
        OpSub  = 5'd4,
        OpAnd  = 5'd5,
        OpOr   = 5'd6,
        OpSrl  = 5'd9,
        OpSll  = 5'd11,
        OpAddi = 5'd12,
        OpBr   = 5'd19,
        OpOut  = 5'd23,
        OpNop  = 5'd26,
        OpHlt  = 5'd27
    } opcodeT;

    // ALU function select
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSll,
        AluSrl
    } aluOpT;

    // Branch condition in bits 20:19
    typedef enum logic [1:0] {
        BrZero = 2'd0,
        BrNzro = 2'd1,
        BrPos  = 2'd2,
        BrNeg  = 2'd3
    } brCondT;

    // One-hot instruction phase
    typedef enum logic [4:0] {
        StepFetch  = 5'b00001,
        StepDecode = 5'b00010,
        StepExec   = 5'b00100,
        StepMem    = 5'b01000,
        StepWrite  = 5'b10000
    } stepT;

endpackage

// File: design/dataPath.sv
`timescale 1ns/10ps

module dataPath #(
    parameter int AddrWidth = 12
) (
    input  logic iClk,
    input  logic nRst,
    ctrlIf.dp ctl,
    memIf.core mem,
    output cpuPkg::wordT outData,
    output logic outValid
);

    cpuPkg::wordT regFile [16];
    cpuPkg::wordT rfA;
    cpuPkg::wordT rfB;
    cpuPkg::wordT opA;
    cpuPkg::wordT opB;
    cpuPkg::wordT aluResult;
    cpuPkg::wordT aluOut;
    cpuPkg::wordT mdr;
    cpuPkg::wordT wbData;
    logic [AddrWidth-1:0] pc;

    // Register file reads, r0 hardwired to zero
    assign rfA = (ctl.addrA == '0) ? '0 : regFile[ctl.addrA];
    assign rfB = (ctl.addrB == '0) ? '0 : regFile[ctl.addrB];

    // Branch flags of port B
    assign ctl.regZero = (rfB == '0);
    assign ctl.regNeg = rfB[31];

    // Write-back mux, LD from memory, everything else from the ALU
    assign wbData = ctl.wbFromMem ? mdr : aluOut;

    always_ff @(posedge iClk) begin
        // Writes to r0 dropped
        if (ctl.rfWrite && ctl.addrC != '0) begin
            regFile[ctl.addrC] <= wbData;
        end
    end

    // Operand and result registers, loaded every cycle
    // Stable from DECODE onward since IR holds
    always_ff @(posedge iClk) begin
        opA <= rfA;
        opB <= ctl.useImm ? ctl.imm : rfB;
        aluOut <= aluResult;
        // Memory data register, last completed read
        if (mem.done) begin
            mdr <= mem.rdata;
        end
    end

    // ALU
    always_comb begin
        case (ctl.aluOp)
            cpuPkg::AluAdd: aluResult = opA + opB;
            cpuPkg::AluSub: aluResult = opA - opB;
            cpuPkg::AluAnd: aluResult = opA & opB;
            cpuPkg::AluOr:  aluResult = opA | opB;
            // Shift amount from low five bits
            cpuPkg::AluSll: aluResult = opA << opB[4:0];
            cpuPkg::AluSrl: aluResult = opA >> opB[4:0];
            default:        aluResult = opA + opB;
        endcase
    end

    // PC, already past the branch when the offset is added
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            pc <= '0;
        end else if (ctl.pcBranch) begin
            pc <= pc + ctl.imm[AddrWidth-1:0];
        end else if (ctl.pcIncr) begin
            pc <= pc + AddrWidth'(1);
        end
    end

    // Fetch from PC, data access from the computed address
    assign mem.addr = ctl.memAddrFromAlu ? aluOut[AddrWidth-1:0] : pc;
    // Store data is ra on port B
    assign mem.wdata = rfB;

    // OUT port register with one-cycle strobe
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= ctl.outLoad;
        end
    end

    always_ff @(posedge iClk) begin
        if (ctl.outLoad) begin
            outData <= rfB;
        end
    end

    // One strobe per OUT, never back to back
    outSinglePulse: assert property (@(posedge iClk) disable iff (!nRst)
        outValid |=> !outValid);

endmodule

// File: design/miniCpu.sv
`timescale 1ns/10ps

module miniCpu #(
    parameter int AddrWidth = 12
) (
    input  logic iClk,
    input  logic nRst,
    // APB requester
    output logic pSel,
    output logic pEnable,
    output logic pWrite,
    output logic [AddrWidth-1:0] pAddr,
    output cpuPkg::wordT pWdata,
    input  cpuPkg::wordT pRdata,
    input  logic pReady,
    // Output port
    output cpuPkg::wordT outData,
    output logic outValid,
    output logic halted
);

    // Control strobes and register addresses
    ctrlIf ctlBus ();
    // Memory request channel, shared by fetch and data access
    memIf #(.AddrWidth(AddrWidth)) memBus ();

    controlUnit controlUnit_i (
        .iClk   (iClk),
        .nRst   (nRst),
        .mem    (memBus),
        .ctl    (ctlBus),
        .halted (halted)
    );

    dataPath #(.AddrWidth(AddrWidth)) dataPath_i (
        .iClk     (iClk),
        .nRst     (nRst),
        .ctl      (ctlBus),
        .mem      (memBus),
        .outData  (outData),
        .outValid (outValid)
    );

    apbRequester #(.AddrWidth(AddrWidth)) apbRequester_i (
        .iClk    (iClk),
        .nRst    (nRst),
        .mem     (memBus),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWdata  (pWdata),
        .pRdata  (pRdata),
        .pReady  (pReady)
    );

endmodule

// File: miniCpu.f
design/cpuPkg.sv
design/coreIfs.sv
design/apbRequester.sv
design/controlUnit.sv
design/dataPath.sv
design/miniCpu.sv
tests/miniCpuTb.sv

// File: run.sh
#!/bin/sh
# Build miniCpuTb with Verilator, run it once and scan the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module miniCpuTb -f miniCpu.f \
    && ./obj_dir/VminiCpuTb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: tests/miniCpuTb.sv
`timescale 1ns/10ps

module miniCpuTb;

    localparam int AddrWidth = 12;
    localparam int MemWords = 4096;
    localparam int NumTests = 6;
    // Data layout of the memory program
    localparam int MemBase = 100;
    localparam int MemValue = 'h12345;
    localparam int DataAddr = 200;
    localparam cpuPkg::wordT DataWord = 32'hCAFEF00D;

    logic iClk;
    logic nRst = 1'b0;
    logic pSel;
    logic pEnable;
    logic pWrite;
    logic [AddrWidth-1:0] pAddr;
    cpuPkg::wordT pWdata;
    cpuPkg::wordT pRdata = '0;
    logic pReady = 1'b0;
    cpuPkg::wordT outData;
    logic outValid;
    logic halted;

    // APB slave memory and wait state control
    cpuPkg::wordT mem [MemWords];
    logic useWaits = 1'b0;
    int waitLeft = 0;
    int waitTotal = 0;
    // Bus history for the protocol monitor
    logic prevSel = 1'b0;
    logic prevEnable = 1'b0;
    logic prevReady = 1'b0;
    logic prevWrite = 1'b0;
    logic [AddrWidth-1:0] prevAddr = '0;
    cpuPkg::wordT prevWdata = '0;
    logic sawSetup = 1'b0;
    logic [AddrWidth-1:0] firstAddr = '0;
    logic firstWrite = 1'b0;
    // Program image, expected OUT values, observed OUT values
    cpuPkg::wordT prog[$];
    cpuPkg::wordT expQ[$];
    cpuPkg::wordT outQ[$];

    miniCpu #(.AddrWidth(AddrWidth)) miniCpu_i (
        .iClk     (iClk),
        .nRst     (nRst),
        .pSel     (pSel),
        .pEnable  (pEnable),
        .pWrite   (pWrite),
        .pAddr    (pAddr),
        .pWdata   (pWdata),
        .pRdata   (pRdata),
        .pReady   (pReady),
        .outData  (outData),
        .outValid (outValid),
        .halted   (halted)
    );

    initial begin
        iClk = 1'b0;
        forever #10 iClk = ~iClk;
    end

    // Tests x 64 instructions x 24 worst-case cycles x clock period
    initial begin
        #(NumTests * 64 * 24 * 20);
        $display("Program did not halt in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    // Instruction words
    function automatic cpuPkg::wordT regOp(cpuPkg::opcodeT op, int ra, int rb, int rc);
        return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
    endfunction

    function automatic cpuPkg::wordT immOp(cpuPkg::opcodeT op, int ra, int rb, int imm);
        return {op, ra[3:0], rb[3:0], imm[18:0]};
    endfunction

    // Target is the word after the branch plus the offset
    function automatic cpuPkg::wordT branchOp(cpuPkg::brCondT cond, int ra, int offset);
        return {cpuPkg::OpBr, ra[3:0], 2'b00, cond, offset[18:0]};
    endfunction

    function automatic cpuPkg::wordT outOp(int ra);
        return {cpuPkg::OpOut, ra[3:0], 23'd0};
    endfunction

    function automatic cpuPkg::wordT haltOp();
        return {cpuPkg::OpHlt, 27'd0};
    endfunction

    // Branch rule on the signed register value
    function automatic logic branchTaken(cpuPkg::brCondT cond, int value);
        case (cond)
            cpuPkg::BrZero: return value == 0;
            cpuPkg::BrNzro: return value != 0;
            cpuPkg::BrPos:  return value > 0;
            default:        return value < 0;
        endcase
    endfunction

    task automatic checkWord(string name, cpuPkg::wordT got, cpuPkg::wordT exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic failRun(string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    // APB slave that counts wait states down in the access phase
    always @(posedge iClk) begin
        if (!nRst) begin
            pReady <= 1'b0;
        end else if (pSel && !pEnable) begin
            waitLeft = useWaits ? int'($urandom % 4) : 0;
            waitTotal = waitTotal + waitLeft;
            pReady <= (waitLeft == 0);
            pRdata <= mem[pAddr];
        end else if (pSel && pEnable && !pReady) begin
            waitLeft = waitLeft - 1;
            pReady <= (waitLeft == 0);
        end else begin
            // Write lands when the access completes
            if (pSel && pEnable && pWrite) begin
                mem[pAddr] = pWdata;
            end
            pReady <= 1'b0;
        end
    end

    // Setup/access protocol monitor
    always @(posedge iClk) begin
        if (!nRst) begin
            sawSetup = 1'b0;
        end else begin
            if (pEnable) begin
                checkBit("pSel", pSel, 1'b1);
                // Fresh access phase needs a setup cycle just before
                if (!(prevEnable && !prevReady)) begin
                    checkBit("pSel before pEnable", prevSel && !prevEnable, 1'b1);
                end
            end
            if (pSel && prevSel && !(prevEnable && prevReady)) begin
                checkWord("pAddr", cpuPkg::wordT'(pAddr), cpuPkg::wordT'(prevAddr));
                checkBit("pWrite", pWrite, prevWrite);
                if (pWrite) begin
                    checkWord("pWdata", pWdata, prevWdata);
                end
            end
            if (pSel && !pEnable && !sawSetup) begin
                sawSetup = 1'b1;
                firstAddr = pAddr;
                firstWrite = pWrite;
            end
        end
        prevSel = pSel;
        prevEnable = pEnable;
        prevReady = pReady;
        prevWrite = pWrite;
        prevAddr = pAddr;
        prevWdata = pWdata;
    end

    // OUT port collector
    always @(posedge iClk) begin
        if (!nRst) begin
            outQ.delete();
        end else if (outValid) begin
            outQ.push_back(outData);
        end
    end

    task automatic clearProgram();
        prog.delete();
        expQ.delete();
    endtask

    task automatic opThenOut(cpuPkg::opcodeT op, int ra, int rb, int rc);
        prog.push_back(regOp(op, ra, rb, rc));
        prog.push_back(outOp(ra));
    endtask

    task automatic loadProgram();
        // Address-tagged fill whose opcode field decodes as HLT
        for (int a = 0; a < MemWords; a++) begin
            mem[a] = 32'hDEAD0000 | a;
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
    endtask

    task automatic applyReset();
        @(posedge iClk);
        nRst <= 1'b0;
        repeat (8) @(posedge iClk);
        // Idle bus and cleared flags while reset is held
        checkBit("pSel", pSel, 1'b0);
        checkBit("pEnable", pEnable, 1'b0);
        checkBit("outValid", outValid, 1'b0);
        checkBit("halted", halted, 1'b0);
        nRst <= 1'b1;
    endtask

    task automatic runProgram();
        applyReset();
        while (!halted) begin
            @(posedge iClk);
        end
        repeat (2) @(posedge iClk);
    endtask

    task automatic checkOuts();
        if (outQ.size() != expQ.size()) begin
            failRun($sformatf("Expected %0d OUT values but saw %0d", expQ.size(), outQ.size()));
        end else begin
            foreach (expQ[i]) begin
                checkWord($sformatf("outData[%0d]", i), outQ[i], expQ[i]);
            end
        end
    endtask

    task automatic testReset();
        clearProgram();
        prog.push_back(immOp(cpuPkg::OpLi, 1, 0, 'h55));
        prog.push_back(outOp(1));
        prog.push_back(haltOp());
        expQ.push_back(32'h55);
        loadProgram();
        runProgram();
        if (!sawSetup) begin
            failRun("No APB transfer started after reset");
        end else begin
            // First transfer is the fetch of word 0
            checkWord("first pAddr", cpuPkg::wordT'(firstAddr), '0);
            checkBit("first pWrite", firstWrite, 1'b0);
            checkOuts();
        end
    endtask

    task automatic testAlu();
        cpuPkg::wordT a;
        cpuPkg::wordT b;
        a = 1234;
        b = -100;
        clearProgram();
        prog.push_back(immOp(cpuPkg::OpLi, 1, 0, 1234));
        prog.push_back(immOp(cpuPkg::OpLi, 2, 0, -100));
        prog.push_back(immOp(cpuPkg::OpLi, 7, 0, 4));
        opThenOut(cpuPkg::OpAdd, 3, 1, 2);
        opThenOut(cpuPkg::OpSub, 4, 1, 2);
        opThenOut(cpuPkg::OpAnd, 5, 1, 2);
        opThenOut(cpuPkg::OpOr, 6, 1, 2);
        opThenOut(cpuPkg::OpSll, 8, 1, 7);
        opThenOut(cpuPkg::OpSrl, 9, 2, 7);
        prog.push_back(immOp(cpuPkg::OpAddi, 10, 1, -1000));
        prog.push_back(outOp(10));
        // r0 drops the write and still reads zero
        prog.push_back(immOp(cpuPkg::OpAddi, 0, 1, 5));
        prog.push_back(outOp(0));
        opThenOut(cpuPkg::OpAdd, 11, 0, 1);
        // Immediate extremes for sign extension
        prog.push_back(immOp(cpuPkg::OpLi, 12, 0, -262144));
        prog.push_back(outOp(12));
        prog.push_back(immOp(cpuPkg::OpLi, 13, 0, 262143));
        prog.push_back(outOp(13));
        prog.push_back(haltOp());
        expQ = '{a + b, a - b, a & b, a | b, a << 4, b >> 4, a - 1000, 32'd0, a,
                 cpuPkg::wordT'(-262144), cpuPkg::wordT'(262143)};
        loadProgram();
        runProgram();
        checkOuts();
    endtask

    // Stores around a base register, then loads back plus one preset word
    task automatic buildMemProgram();
        clearProgram();
        prog.push_back(immOp(cpuPkg::OpLi, 1, 0, MemBase));
        prog.push_back(immOp(cpuPkg::OpLi, 2, 0, MemValue));
        prog.push_back(immOp(cpuPkg::OpSt, 2, 1, 5));
        prog.push_back(immOp(cpuPkg::OpAddi, 3, 2, 1));
        prog.push_back(immOp(cpuPkg::OpSt, 3, 1, -3));
        prog.push_back(immOp(cpuPkg::OpLd, 4, 1, 5));
        prog.push_back(outOp(4));
        prog.push_back(immOp(cpuPkg::OpLd, 5, 1, -3));
        prog.push_back(outOp(5));
        prog.push_back(immOp(cpuPkg::OpLd, 6, 0, DataAddr));
        prog.push_back(outOp(6));
        prog.push_back(haltOp());
        expQ = '{cpuPkg::wordT'(MemValue), cpuPkg::wordT'(MemValue + 1), DataWord};
        loadProgram();
        mem[DataAddr] = DataWord;
    endtask

    task automatic checkMemWords();
        checkWord("mem[base+5]", mem[MemBase + 5], cpuPkg::wordT'(MemValue));
        checkWord("mem[base-3]", mem[MemBase - 3], cpuPkg::wordT'(MemValue + 1));
    endtask

    task automatic testMemory();
        useWaits = 1'b0;
        buildMemProgram();
        runProgram();
        checkOuts();
        checkMemWords();
    endtask

    task automatic testBranches();
        cpuPkg::brCondT conds [8];
        int vals [8];
        int loopStart;
        clearProgram();
        conds = '{cpuPkg::BrZero, cpuPkg::BrZero, cpuPkg::BrNzro, cpuPkg::BrNzro,
                  cpuPkg::BrPos, cpuPkg::BrPos, cpuPkg::BrNeg, cpuPkg::BrNeg};
        vals = '{0, 5, 5, 0, 5, -2, -2, 0};
        // Taken branch skips the OUT of its case id
        for (int i = 0; i < 8; i++) begin
            prog.push_back(immOp(cpuPkg::OpLi, 4, 0, vals[i]));
            prog.push_back(immOp(cpuPkg::OpLi, 6, 0, i + 1));
            prog.push_back(branchOp(conds[i], 4, 1));
            prog.push_back(outOp(6));
            if (!branchTaken(conds[i], vals[i])) begin
                expQ.push_back(cpuPkg::wordT'(i + 1));
            end
        end
        // Backward loop counting r7 down to zero
        prog.push_back(immOp(cpuPkg::OpLi, 7, 0, 3));
        loopStart = prog.size();
        prog.push_back(outOp(7));
        prog.push_back(immOp(cpuPkg::OpAddi, 7, 7, -1));
        prog.push_back(branchOp(cpuPkg::BrNzro, 7, loopStart - prog.size() - 1));
        prog.push_back(haltOp());
        for (int v = 3; v > 0; v--) begin
            expQ.push_back(cpuPkg::wordT'(v));
        end
        loadProgram();
        runProgram();
        checkOuts();
    endtask

    task automatic testBackPressure();
        int startWaits;
        startWaits = waitTotal;
        useWaits = 1'b1;
        buildMemProgram();
        runProgram();
        useWaits = 1'b0;
        if (waitTotal == startWaits) begin
            failRun("No wait states were inserted on the bus");
        end else begin
            checkOuts();
            checkMemWords();
        end
    endtask

    task automatic testHalt();
        clearProgram();
        prog.push_back(immOp(cpuPkg::OpLi, 1, 0, 9));
        prog.push_back(outOp(1));
        prog.push_back(haltOp());
        // Never executed
        prog.push_back(outOp(1));
        expQ.push_back(32'd9);
        loadProgram();
        runProgram();
        repeat (100) begin
            @(posedge iClk);
            checkBit("halted", halted, 1'b1);
            checkBit("pSel", pSel, 1'b0);
        end
        checkOuts();
    endtask

    initial begin
        void'($urandom(32'h38e6));
        testReset();
        testAlu();
        testMemory();
        testBranches();
        testBackPressure();
        testHalt();
        $display("TEST OK");
        $finish;
    end

endmodule
